//--- Bender.yml
package:
  name: ex_stage

sources:
  - files:
      - source/ex_pkg.sv
      - source/ex_div.sv
      - source/ex_alu.sv
      - source/ex_bcu.sv
      - source/ex_stage.sv
      - source/ex_top.sv
  - target: test
    files:
      - bench/ex_assert.sv
      - bench/tb_ex_top.sv

//--- bench/ex_assert.sv
`timescale 1ns/1ps

module ex_assert
    import ex_pkg::*;
(
    input logic    clk,
    input logic    arst_n_i,
    input ex_res_t res_i,
    input logic    stall_i
);

    // register is cleared asynchronously
    property p_valid_in_reset;
        @(posedge clk) !arst_n_i |-> !res_i.valid;
    endproperty

    property p_hold_on_stall;
        @(posedge clk) disable iff (!arst_n_i)
            stall_i |=> $stable(res_i);
    endproperty

    // a slot is either a load or a store
    property p_one_strobe;
        @(posedge clk) disable iff (!arst_n_i)
            !(res_i.rden && res_i.wren);
    endproperty

    a_valid_in_reset: assert property (p_valid_in_reset)
        else $error("registered result valid during reset");

    a_hold_on_stall: assert property (p_hold_on_stall)
        else $error("registered result changed while stalled");

    a_one_strobe: assert property (p_one_strobe)
        else $error("load and store strobes both high");

endmodule

bind ex_top ex_assert u_ex_assert (
    .clk      (clk),
    .arst_n_i (arst_n_i),
    .res_i    (res_o),
    .stall_i  (stall_o)
);

//--- bench/tb_ex_top.sv
`timescale 1ns/1ps

module tb_ex_top
    import ex_pkg::*;
();

    logic            clk;
    logic            arst_n;
    ex_req_t         req;
    logic            req_valid;
    logic [XLEN-1:0] ls_fw;
    logic [XLEN-1:0] wb_fw;
    logic            ls_addr_ok;
    ex_res_t         res;
    brc_res_t        brc;
    logic            stall;

    integer          seed;
    int              value_errs;
    int              other_errs;
    logic [XLEN-1:0] last_alures;

    ex_top u_ex_top (
        .clk          (clk),
        .arst_n_i     (arst_n),
        .req_i        (req),
        .req_valid_i  (req_valid),
        .ls_fw_i      (ls_fw),
        .wb_fw_i      (wb_fw),
        .ls_addr_ok_i (ls_addr_ok),
        .res_o        (res),
        .brc_o        (brc),
        .stall_o      (stall)
    );

    always #5 clk = ~clk;

    task automatic report_mismatch(input string name, input logic [XLEN-1:0] exp,
                                   input logic [XLEN-1:0] act);
        value_errs++;
        $display("** Error: %s expected %h actual %h at %0t", name, exp, act, $time);
    endtask

    task automatic report_failure(input string what);
        other_errs++;
        $display("error at %0t: %s", $time, what);
    endtask

    function automatic logic [INST_LEN-1:0] make_instr(input opcode_e opc, input logic [2:0] f3);
        return {17'b0, f3, 5'b0, opc, 2'b11};
    endfunction

    // add of register-file operands with rs2 as source 2
    function automatic ex_req_t base_req();
        ex_req_t r;
        r          = '0;
        r.aluctr   = ALU_ADD;
        r.src2_sel = SRC2_RS2;
        r.rs1_sel  = FW_RF;
        r.rs2_sel  = FW_RF;
        r.div_sel  = DIV_DIV;
        r.instr    = make_instr(OPC_OP, 3'b000);
        r.pc       = $random(seed) & 32'hffff_fffc;
        return r;
    endfunction

    function automatic logic [XLEN-1:0] alu_model(input alu_op_e op, input logic [XLEN-1:0] a,
                                                  input logic [XLEN-1:0] b);
        logic signed [63:0] sa;
        logic signed [63:0] sb;
        logic signed [63:0] zb;
        logic        [63:0] ua;
        logic        [63:0] ub;
        logic        [63:0] p;
        logic        [4:0]  sh;
        sa = {{32{a[31]}}, a};
        sb = {{32{b[31]}}, b};
        zb = {32'b0, b};
        ua = {32'b0, a};
        ub = {32'b0, b};
        sh = b[4:0];
        p  = '0;
        case (op)
            ALU_ADD:    return a + b;
            ALU_SUB:    return a - b;
            ALU_SLL:    return a << sh;
            ALU_SLT:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            ALU_SLTU:   return (a < b) ? 32'd1 : 32'd0;
            ALU_XOR:    return a ^ b;
            ALU_SRL:    return a >> sh;
            // logical shift with the sign bits filled in on top
            ALU_SRA:    return (a >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 32'h0);
            ALU_OR:     return a | b;
            ALU_AND:    return a & b;
            ALU_LUI:    return b;
            ALU_MUL:    p = ua * ub;
            ALU_MULH:   p = sa * sb;
            ALU_MULHSU: p = sa * zb;
            ALU_MULHU:  p = ua * ub;
            default:    return 32'h0;
        endcase
        return (op == ALU_MUL) ? p[31:0] : p[63:32];
    endfunction

    function automatic logic [XLEN-1:0] div_model(input div_op_e op, input logic [XLEN-1:0] a,
                                                  input logic [XLEN-1:0] b);
        logic is_rem;
        is_rem = (op == DIV_REM) || (op == DIV_REMU);
        if (b == 32'h0) begin
            return is_rem ? a : 32'hffff_ffff;
        end
        // signed overflow case of the spec
        if ((op == DIV_DIV || op == DIV_REM) && a == 32'h8000_0000 && b == 32'hffff_ffff) begin
            return is_rem ? 32'h0 : 32'h8000_0000;
        end
        case (op)
            DIV_DIV:  return $signed(a) / $signed(b);
            DIV_REM:  return $signed(a) % $signed(b);
            DIV_DIVU: return a / b;
            default:  return a % b;
        endcase
    endfunction

    function automatic brc_res_t brc_model(input ex_req_t r);
        brc_res_t        b;
        logic            cond;
        logic [XLEN-1:0] sum;
        case (r.instr[14:12])
            3'b000:  cond = (r.rs1 == r.rs2);
            3'b001:  cond = (r.rs1 != r.rs2);
            3'b100:  cond = ($signed(r.rs1) < $signed(r.rs2));
            3'b101:  cond = ($signed(r.rs1) >= $signed(r.rs2));
            3'b110:  cond = (r.rs1 < r.rs2);
            3'b111:  cond = (r.rs1 >= r.rs2);
            default: cond = 1'b0;
        endcase
        sum = r.rs1 + r.imm;
        if (r.is_jalr) begin
            b.pc_next = sum & 32'hffff_fffe;
            b.is_jump = 1'b1;
        end else if (r.is_jal || (r.is_brc && cond)) begin
            b.pc_next = r.pc + r.imm;
            b.is_jump = 1'b1;
        end else begin
            b.pc_next = r.pc + 32'd4;
            b.is_jump = 1'b0;
        end
        return b;
    endfunction

    // drive at the falling edge and check after the next capture
    task automatic issue_and_check(input ex_req_t r, input logic [XLEN-1:0] exp);
        req       = r;
        req_valid = 1'b1;
        @(posedge clk);
        @(negedge clk);
        if (res.alures !== exp) report_mismatch("res_o.alures", exp, res.alures);
        if (res.valid !== 1'b1) report_mismatch("res_o.valid", 32'h1, {31'b0, res.valid});
        last_alures = exp;
    endtask

    task automatic test_alu_ops();
        ex_req_t r;
        alu_op_e op;
        int      i;
        int      k;
        for (i = 0; i < 15; i++) begin
            op = alu_op_e'(i);
            for (k = 0; k < 4; k++) begin
                r        = base_req();
                r.aluctr = op;
                r.rs1    = $random(seed);
                r.rs2    = $random(seed);
                // corner for the signed multiplies
                if (k == 0) begin
                    r.rs1 = 32'h8000_0000;
                    r.rs2 = 32'hffff_ffff;
                end
                issue_and_check(r, alu_model(op, r.rs1, r.rs2));
            end
        end
    endtask

    task automatic test_forwarding();
        ex_req_t         r;
        logic [XLEN-1:0] a;
        a     = $random(seed);
        ls_fw = $random(seed);
        wb_fw = $random(seed);
        r          = base_req();
        r.rs1      = a;
        r.src2_sel = SRC2_ZERO;
        issue_and_check(r, a);
        // ex source is the result registered one edge ago
        r.rs1_sel  = FW_EX;
        r.rs1      = ~a;
        r.src2_sel = SRC2_IMM;
        r.imm      = 32'h5;
        issue_and_check(r, last_alures + 32'h5);
        r.rs1_sel  = FW_LS;
        r.src2_sel = SRC2_ZERO;
        issue_and_check(r, ls_fw);
        r.rs1_sel = FW_WB;
        issue_and_check(r, wb_fw);
        // second operand through each source
        r          = base_req();
        r.rs2      = a;
        r.src2_sel = SRC2_RS2;
        r.rs2_sel  = FW_LS;
        issue_and_check(r, ls_fw);
        if (res.rs2 !== ls_fw) report_mismatch("res_o.rs2", ls_fw, res.rs2);
        // ls source moves so the ex value stands apart
        ls_fw     = ~ls_fw;
        r.rs2_sel = FW_EX;
        issue_and_check(r, last_alures);
        r.rs2_sel = FW_WB;
        issue_and_check(r, wb_fw);
        if (res.rs2 !== wb_fw) report_mismatch("res_o.rs2", wb_fw, res.rs2);
        r.rs2_sel = FW_RF;
        issue_and_check(r, a);
        // link value pc + 4
        r          = base_req();
        r.src1_sel = 1'b1;
        r.src2_sel = SRC2_FOUR;
        issue_and_check(r, r.pc + 32'd4);
        r          = base_req();
        r.rs1      = a;
        r.imm      = $random(seed);
        r.src2_sel = SRC2_IMM;
        issue_and_check(r, a + r.imm);
        r.aluctr   = ALU_OR;
        r.src2_sel = SRC2_ZERO;
        r.rs2      = ~a;
        issue_and_check(r, a);
    endtask

    task automatic run_branch(input ex_req_t r);
        brc_res_t exp;
        exp = brc_model(r);
        req = r;
        #1;
        if (brc.is_jump !== exp.is_jump) begin
            report_mismatch("brc_o.is_jump", {31'b0, exp.is_jump}, {31'b0, brc.is_jump});
        end
        if (brc.pc_next !== exp.pc_next) report_mismatch("brc_o.pc_next", exp.pc_next, brc.pc_next);
        @(posedge clk);
        @(negedge clk);
    endtask

    task automatic test_branches();
        ex_req_t r;
        int      f;
        int      p;
        for (f = 0; f < 8; f++) begin
            for (p = 0; p < 4; p++) begin
                r        = base_req();
                r.instr  = make_instr(OPC_BRANCH, f[2:0]);
                r.is_brc = 1'b1;
                r.imm    = $random(seed) & 32'h0000_1ffe;
                r.rs1    = $random(seed);
                r.rs2    = $random(seed);
                case (p)
                    0: r.rs2 = r.rs1;
                    2: begin
                        r.rs1 = 32'hffff_fff0;
                        r.rs2 = 32'h0000_0010;
                    end
                    3: begin
                        r.rs1 = 32'h0000_0010;
                        r.rs2 = 32'hffff_fff0;
                    end
                    default: ;
                endcase
                run_branch(r);
            end
        end
        r        = base_req();
        r.instr  = make_instr(OPC_JAL, 3'b000);
        r.is_jal = 1'b1;
        r.imm    = $random(seed) & 32'h000f_fffe;
        run_branch(r);
        // odd sum so bit 0 must be cleared
        r         = base_req();
        r.instr   = make_instr(OPC_JALR, 3'b000);
        r.is_jalr = 1'b1;
        r.rs1     = $random(seed) | 32'h1;
        r.imm     = $random(seed) & 32'h0000_0ffe;
        run_branch(r);
        r = base_req();
        run_branch(r);
    endtask

    task automatic run_divide(input div_op_e op, input logic [XLEN-1:0] a,
                              input logic [XLEN-1:0] b);
        ex_req_t         r;
        logic [XLEN-1:0] exp;
        int              cnt;
        r         = base_req();
        r.div_en  = 1'b1;
        r.div_sel = op;
        r.rs1     = a;
        r.rs2     = b;
        exp       = div_model(op, a, b);
        req       = r;
        req_valid = 1'b1;
        #1;
        if (stall !== 1'b1) report_failure("stall did not rise on a divide request");
        cnt = 0;
        while (stall !== 1'b0 && cnt < 64) begin
            @(negedge clk);
            cnt++;
        end
        if (stall !== 1'b0) begin
            report_failure("stall did not fall within 64 cycles of a divide");
        end else begin
            @(posedge clk);
            @(negedge clk);
            if (res.alures !== exp) report_mismatch("res_o.alures", exp, res.alures);
        end
    endtask

    task automatic test_divide();
        logic [XLEN-1:0] a;
        int              i;
        int              k;
        for (i = 0; i < 4; i++) begin
            for (k = 0; k < 3; k++) begin
                run_divide(div_op_e'(i), $random(seed), $random(seed));
            end
        end
        a = $random(seed);
        for (i = 0; i < 4; i++) begin
            run_divide(div_op_e'(i), a, 32'h0);
        end
        for (i = 0; i < 4; i++) begin
            run_divide(div_op_e'(i), 32'h8000_0000, 32'hffff_ffff);
        end
    endtask

    task automatic test_mem_backpressure();
        ex_req_t         r;
        logic [XLEN-1:0] hold;
        r          = base_req();
        r.instr    = make_instr(OPC_STORE, 3'b010);
        r.rs1      = $random(seed);
        r.rs2      = $random(seed);
        r.imm      = 32'h40;
        r.src2_sel = SRC2_IMM;
        issue_and_check(r, r.rs1 + 32'h40);
        if (res.wren !== 1'b1) report_mismatch("res_o.wren", 32'h1, {31'b0, res.wren});
        if (res.rden !== 1'b0) report_mismatch("res_o.rden", 32'h0, {31'b0, res.rden});
        if (res.rs2 !== r.rs2) report_mismatch("res_o.rs2", r.rs2, res.rs2);
        r.instr = make_instr(OPC_LOAD, 3'b010);
        r.rs1   = $random(seed);
        hold    = r.rs1 + 32'h40;
        issue_and_check(r, hold);
        if (res.rden !== 1'b1) report_mismatch("res_o.rden", 32'h1, {31'b0, res.rden});
        if (res.wren !== 1'b0) report_mismatch("res_o.wren", 32'h0, {31'b0, res.wren});
        // memory refuses the address for a while
        r          = base_req();
        r.rs1      = $random(seed);
        r.rs2      = $random(seed);
        req        = r;
        ls_addr_ok = 1'b0;
        #1;
        if (stall !== 1'b1) report_failure("stall low while address-ok is low");
        repeat (5) begin
            @(negedge clk);
            if (stall !== 1'b1) report_failure("stall dropped while address-ok is low");
            if (res.alures !== hold) report_mismatch("res_o.alures", hold, res.alures);
            if (res.rden !== 1'b1) report_mismatch("res_o.rden", 32'h1, {31'b0, res.rden});
        end
        ls_addr_ok = 1'b1;
        issue_and_check(r, r.rs1 + r.rs2);
        if (res.rden !== 1'b0) report_mismatch("res_o.rden", 32'h0, {31'b0, res.rden});
    endtask

    initial begin
        clk         = 1'b0;
        arst_n      = 1'b0;
        req         = '0;
        req_valid   = 1'b0;
        ls_fw       = '0;
        wb_fw       = '0;
        ls_addr_ok  = 1'b1;
        seed        = 32'ha05a;
        value_errs  = 0;
        other_errs  = 0;
        last_alures = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        if (res.valid !== 1'b0) report_mismatch("res_o.valid", 32'h0, {31'b0, res.valid});
        arst_n = 1'b1;
        test_alu_ops();
        test_forwarding();
        test_branches();
        test_divide();
        test_mem_backpressure();
        $display("value errors: %0d, other errors: %0d", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- compile.f
source/ex_pkg.sv
source/ex_div.sv
source/ex_alu.sv
source/ex_bcu.sv
source/ex_stage.sv
source/ex_top.sv
bench/ex_assert.sv
bench/tb_ex_top.sv

//--- source/ex_alu.sv
`timescale 1ns/1ps

module ex_alu
    import ex_pkg::*;
(
    input  logic            clk,
    input  logic            arst_n_i,
    input  alu_op_e         alu_op_i,
    input  logic [XLEN-1:0] src1_i,
    input  logic [XLEN-1:0] src2_i,
    input  logic            div_en_i,
    input  div_op_e         div_sel_i,
    output logic [XLEN-1:0] alures_o,
    output logic            not_ok_o
);

    logic [SHAMT_W-1:0]       shamt;
    logic [XLEN-1:0]          op_res;
    logic                     mul_sa;
    logic                     mul_sb;
    logic signed [XLEN:0]     mul_a;
    logic signed [XLEN:0]     mul_b;
    logic signed [2*XLEN+1:0] mul_prod;

    logic            div_start;
    logic            div_busy;
    logic            div_done;
    logic            same_req;
    logic [XLEN-1:0] div_res;

    // operands of the last started divide
    logic            key_vld_q;
    logic [XLEN-1:0] key_a_q;
    logic [XLEN-1:0] key_b_q;
    div_op_e         key_op_q;

    assign shamt = src2_i[SHAMT_W-1:0];

    // one 33x33 signed multiplier covers all four variants
    assign mul_sa   = (alu_op_i == ALU_MULH) || (alu_op_i == ALU_MULHSU);
    assign mul_sb   = (alu_op_i == ALU_MULH);
    assign mul_a    = $signed({mul_sa & src1_i[XLEN-1], src1_i});
    assign mul_b    = $signed({mul_sb & src2_i[XLEN-1], src2_i});
    assign mul_prod = mul_a * mul_b;

    always_comb begin
        case (alu_op_i)
            ALU_ADD:    op_res = src1_i + src2_i;
            ALU_SUB:    op_res = src1_i - src2_i;
            ALU_SLL:    op_res = src1_i << shamt;
            ALU_SLT:    op_res = {{(XLEN-1){1'b0}}, $signed(src1_i) < $signed(src2_i)};
            ALU_SLTU:   op_res = {{(XLEN-1){1'b0}}, src1_i < src2_i};
            ALU_XOR:    op_res = src1_i ^ src2_i;
            ALU_SRL:    op_res = src1_i >> shamt;
            ALU_SRA:    op_res = $unsigned($signed(src1_i) >>> shamt);
            ALU_OR:     op_res = src1_i | src2_i;
            ALU_AND:    op_res = src1_i & src2_i;
            ALU_LUI:    op_res = src2_i;
            ALU_MUL:    op_res = mul_prod[XLEN-1:0];
            ALU_MULH,
            ALU_MULHSU,
            ALU_MULHU:  op_res = mul_prod[2*XLEN-1:XLEN];
            default:    op_res = '0;
        endcase
    end

    // held request matches the divide already run
    assign same_req  = (src1_i == key_a_q) && (src2_i == key_b_q) && (div_sel_i == key_op_q);
    assign div_done  = key_vld_q && same_req && !div_busy;
    assign div_start = div_en_i && !div_busy && !div_done;
    assign not_ok_o  = div_en_i && !div_done;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            key_vld_q <= 1'b0;
        end else if (div_start) begin
            key_vld_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (div_start) begin
            key_a_q  <= src1_i;
            key_b_q  <= src2_i;
            key_op_q <= div_sel_i;
        end
    end

    ex_div u_ex_div (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .start_i    (div_start),
        .op_i       (div_sel_i),
        .dividend_i (src1_i),
        .divisor_i  (src2_i),
        .result_o   (div_res),
        .busy_o     (div_busy)
    );

    assign alures_o = div_en_i ? div_res : op_res;

endmodule

//--- source/ex_bcu.sv
`timescale 1ns/1ps

module ex_bcu
    import ex_pkg::*;
(
    input  logic [XLEN-1:0] rs1_i,
    input  logic [XLEN-1:0] rs2_i,
    input  logic            is_jal_i,
    input  logic            is_jalr_i,
    input  logic            is_brc_i,
    input  logic [2:0]      funct3_i,
    input  logic [XLEN-1:0] imm_i,
    input  logic [XLEN-1:0] pc_i,
    output brc_res_t        brc_o
);

    logic            cond;
    logic            taken;
    logic [XLEN-1:0] jalr_sum;

    always_comb begin
        case (brc_f3_e'(funct3_i))
            BRC_BEQ:  cond = (rs1_i == rs2_i);
            BRC_BNE:  cond = (rs1_i != rs2_i);
            BRC_BLT:  cond = ($signed(rs1_i) < $signed(rs2_i));
            BRC_BGE:  cond = ($signed(rs1_i) >= $signed(rs2_i));
            BRC_BLTU: cond = (rs1_i < rs2_i);
            BRC_BGEU: cond = (rs1_i >= rs2_i);
            // 010 and 011 are not branches
            default:  cond = 1'b0;
        endcase
    end

    assign taken    = is_brc_i && cond;
    assign jalr_sum = rs1_i + imm_i;

    always_comb begin
        if (is_jalr_i) begin
            brc_o.pc_next = {jalr_sum[XLEN-1:1], 1'b0};
            brc_o.is_jump = 1'b1;
        end else if (is_jal_i || taken) begin
            brc_o.pc_next = pc_i + imm_i;
            brc_o.is_jump = 1'b1;
        end else begin
            // fall through
            brc_o.pc_next = pc_i + XLEN'(4);
            brc_o.is_jump = 1'b0;
        end
    end

endmodule

//--- source/ex_div.sv
`timescale 1ns/1ps

module ex_div
    import ex_pkg::*;
(
    input  logic            clk,
    input  logic            arst_n_i,
    input  logic            start_i,
    input  div_op_e         op_i,
    input  logic [XLEN-1:0] dividend_i,
    input  logic [XLEN-1:0] divisor_i,
    output logic [XLEN-1:0] result_o,
    output logic            busy_o
);

    div_state_e           state_q;
    logic [DIV_CNT_W-1:0] cnt_q;

    logic [XLEN-1:0] quo_q;
    logic [XLEN-1:0] rem_q;
    logic [XLEN-1:0] dvs_q;
    logic [XLEN-1:0] dvd_q;
    logic [XLEN-1:0] result_q;
    logic            neg_quo_q;
    logic            neg_rem_q;
    logic            is_rem_q;
    logic            dz_q;

    logic            is_signed;
    logic            is_rem;
    logic            accept;
    logic [XLEN-1:0] abs_dvd;
    logic [XLEN-1:0] abs_dvs;
    logic [XLEN:0]   rem_shift;
    logic [XLEN:0]   rem_diff;

    assign is_signed = (op_i == DIV_DIV) || (op_i == DIV_REM);
    assign is_rem    = (op_i == DIV_REM) || (op_i == DIV_REMU);
    assign accept    = (state_q == DS_IDLE) && start_i;

    // magnitudes of the operands
    // -2^31 stays 0x80000000 which is right unsigned
    assign abs_dvd = (is_signed && dividend_i[XLEN-1]) ? -dividend_i : dividend_i;
    assign abs_dvs = (is_signed && divisor_i[XLEN-1]) ? -divisor_i : divisor_i;

    // one restoring step per cycle
    assign rem_shift = {rem_q, quo_q[XLEN-1]};
    assign rem_diff  = rem_shift - {1'b0, dvs_q};

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= DS_IDLE;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                DS_IDLE: begin
                    if (start_i) begin
                        cnt_q <= '0;
                        // divide by zero skips straight to the fixup
                        state_q <= (divisor_i == '0) ? DS_FIX : DS_CALC;
                    end
                end
                DS_CALC: begin
                    cnt_q <= cnt_q + 1'b1;
                    if (cnt_q == DIV_CNT_W'(XLEN - 1)) begin
                        state_q <= DS_FIX;
                    end
                end
                DS_FIX: begin
                    state_q <= DS_IDLE;
                end
                default: begin
                    state_q <= DS_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            quo_q     <= abs_dvd;
            rem_q     <= '0;
            dvs_q     <= abs_dvs;
            dvd_q     <= dividend_i;
            neg_quo_q <= is_signed && (dividend_i[XLEN-1] ^ divisor_i[XLEN-1]);
            neg_rem_q <= is_signed && dividend_i[XLEN-1];
            is_rem_q  <= is_rem;
            dz_q      <= (divisor_i == '0);
        end else if (state_q == DS_CALC) begin
            if (!rem_diff[XLEN]) begin
                rem_q <= rem_diff[XLEN-1:0];
                quo_q <= {quo_q[XLEN-2:0], 1'b1};
            end else begin
                rem_q <= rem_shift[XLEN-1:0];
                quo_q <= {quo_q[XLEN-2:0], 1'b0};
            end
        end
    end

    // sign fixup held until the next start
    always_ff @(posedge clk) begin
        if (state_q == DS_FIX) begin
            if (dz_q) begin
                result_q <= is_rem_q ? dvd_q : '1;
            end else if (is_rem_q) begin
                result_q <= neg_rem_q ? -rem_q : rem_q;
            end else begin
                result_q <= neg_quo_q ? -quo_q : quo_q;
            end
        end
    end

    assign result_o = result_q;
    assign busy_o   = (state_q != DS_IDLE);

endmodule

//--- source/ex_pkg.sv
package ex_pkg;

    localparam int XLEN      = 32;
    localparam int INST_LEN  = 32;
    localparam int SHAMT_W   = $clog2(XLEN);
    localparam int DIV_CNT_W = $clog2(XLEN);

    // alu operation select from decode
    typedef enum logic [4:0] {
        ALU_ADD    = 5'd0,
        ALU_SUB    = 5'd1,
        ALU_SLL    = 5'd2,
        ALU_SLT    = 5'd3,
        ALU_SLTU   = 5'd4,
        ALU_XOR    = 5'd5,
        ALU_SRL    = 5'd6,
        ALU_SRA    = 5'd7,
        ALU_OR     = 5'd8,
        ALU_AND    = 5'd9,
        ALU_LUI    = 5'd10,
        ALU_MUL    = 5'd11,
        ALU_MULH   = 5'd12,
        ALU_MULHSU = 5'd13,
        ALU_MULHU  = 5'd14
    } alu_op_e;

    typedef enum logic [2:0] {
        DIV_DIV  = 3'd0,
        DIV_DIVU = 3'd1,
        DIV_REM  = 3'd2,
        DIV_REMU = 3'd3
    } div_op_e;

    // forwarding source of an operand
    typedef enum logic [1:0] {
        FW_RF = 2'd0,
        FW_EX = 2'd1,
        FW_LS = 2'd2,
        FW_WB = 2'd3
    } fw_sel_e;

    typedef enum logic [1:0] {
        SRC2_RS2  = 2'd0,
        SRC2_IMM  = 2'd1,
        SRC2_ZERO = 2'd2,
        SRC2_FOUR = 2'd3
    } src2_sel_e;

    // major opcode in instr[6:2]
    typedef enum logic [4:0] {
        OPC_LOAD   = 5'b00000,
        OPC_STORE  = 5'b01000,
        OPC_BRANCH = 5'b11000,
        OPC_JAL    = 5'b11011,
        OPC_JALR   = 5'b11001,
        OPC_OP     = 5'b01100,
        OPC_OP_IMM = 5'b00100,
        OPC_LUI    = 5'b01101,
        OPC_AUIPC  = 5'b00101
    } opcode_e;

    // branch funct3
    typedef enum logic [2:0] {
        BRC_BEQ  = 3'b000,
        BRC_BNE  = 3'b001,
        BRC_BLT  = 3'b100,
        BRC_BGE  = 3'b101,
        BRC_BLTU = 3'b110,
        BRC_BGEU = 3'b111
    } brc_f3_e;

    typedef enum logic [1:0] {
        DS_IDLE = 2'd0,
        DS_CALC = 2'd1,
        DS_FIX  = 2'd2
    } div_state_e;

    typedef struct packed {
        logic [XLEN-1:0]     pc;
        logic [INST_LEN-1:0] instr;
        logic [XLEN-1:0]     rs1;
        logic [XLEN-1:0]     rs2;
        logic [XLEN-1:0]     imm;
        alu_op_e             aluctr;
        logic                is_jal;
        logic                is_jalr;
        logic                is_brc;
        logic                src1_sel;
        src2_sel_e           src2_sel;
        fw_sel_e             rs1_sel;
        fw_sel_e             rs2_sel;
        logic                div_en;
        div_op_e             div_sel;
    } ex_req_t;

    typedef struct packed {
        logic [XLEN-1:0] ex;
        logic [XLEN-1:0] ls;
        logic [XLEN-1:0] wb;
    } fw_data_t;

    typedef struct packed {
        logic [XLEN-1:0] alures;
        logic [XLEN-1:0] rs2;
        logic            rden;
        logic            wren;
        logic            valid;
    } ex_res_t;

    typedef struct packed {
        logic [XLEN-1:0] pc_next;
        logic            is_jump;
    } brc_res_t;

endpackage

//--- source/ex_stage.sv
`timescale 1ns/1ps

module ex_stage
    import ex_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n_i,
    input  ex_req_t  req_i,
    input  fw_data_t fw_i,
    input  logic     ls_addr_ok_i,
    output ex_res_t  res_o,
    output brc_res_t brc_o,
    output logic     stall_o
);

    logic [XLEN-1:0] rs1;
    logic [XLEN-1:0] rs2;
    logic [XLEN-1:0] src1;
    logic [XLEN-1:0] src2;
    logic [XLEN-1:0] alures;
    logic            alu_not_ok;
    opcode_e         opcode;
    logic            full_op;

    function automatic logic [XLEN-1:0] fw_pick(
        input fw_sel_e         sel,
        input logic [XLEN-1:0] rf_val,
        input fw_data_t        fw
    );
        logic [XLEN-1:0] val;
        case (sel)
            FW_EX:   val = fw.ex;
            FW_LS:   val = fw.ls;
            FW_WB:   val = fw.wb;
            default: val = rf_val;
        endcase
        return val;
    endfunction

    // hazard unit supplies the selects
    assign rs1 = fw_pick(req_i.rs1_sel, req_i.rs1, fw_i);
    assign rs2 = fw_pick(req_i.rs2_sel, req_i.rs2, fw_i);

    assign src1 = req_i.src1_sel ? req_i.pc : rs1;

    always_comb begin
        case (req_i.src2_sel)
            SRC2_IMM:  src2 = req_i.imm;
            SRC2_ZERO: src2 = '0;
            SRC2_FOUR: src2 = XLEN'(4);
            default:   src2 = rs2;
        endcase
    end

    ex_alu u_ex_alu (
        .clk       (clk),
        .arst_n_i  (arst_n_i),
        .alu_op_i  (req_i.aluctr),
        .src1_i    (src1),
        .src2_i    (src2),
        .div_en_i  (req_i.div_en),
        .div_sel_i (req_i.div_sel),
        .alures_o  (alures),
        .not_ok_o  (alu_not_ok)
    );

    ex_bcu u_ex_bcu (
        .rs1_i     (rs1),
        .rs2_i     (rs2),
        .is_jal_i  (req_i.is_jal),
        .is_jalr_i (req_i.is_jalr),
        .is_brc_i  (req_i.is_brc),
        .funct3_i  (req_i.instr[14:12]),
        .imm_i     (req_i.imm),
        .pc_i      (req_i.pc),
        .brc_o     (brc_o)
    );

    // 32-bit encodings only
    assign opcode  = opcode_e'(req_i.instr[6:2]);
    assign full_op = (req_i.instr[1:0] == 2'b11);

    assign stall_o = alu_not_ok || !ls_addr_ok_i;

    assign res_o.alures = alures;
    assign res_o.rs2    = rs2;
    assign res_o.rden   = full_op && (opcode == OPC_LOAD);
    assign res_o.wren   = full_op && (opcode == OPC_STORE);
    // result complete this cycle
    assign res_o.valid  = !stall_o;

endmodule

//--- source/ex_top.sv
`timescale 1ns/1ps

module ex_top
    import ex_pkg::*;
(
    input  logic            clk,
    input  logic            arst_n_i,
    input  ex_req_t         req_i,
    input  logic            req_valid_i,
    input  logic [XLEN-1:0] ls_fw_i,
    input  logic [XLEN-1:0] wb_fw_i,
    input  logic            ls_addr_ok_i,
    output ex_res_t         res_o,
    output brc_res_t        brc_o,
    output logic            stall_o
);

    fw_data_t fw;
    ex_res_t  stage_res;
    logic     stall;

    // execute-to-load/store register
    logic            valid_q;
    logic            rden_q;
    logic            wren_q;
    logic [XLEN-1:0] alures_q;
    logic [XLEN-1:0] rs2_q;

    // ex source is this register's own result
    assign fw = '{ex: alures_q, ls: ls_fw_i, wb: wb_fw_i};

    ex_stage u_ex_stage (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .req_i        (req_i),
        .fw_i         (fw),
        .ls_addr_ok_i (ls_addr_ok_i),
        .res_o        (stage_res),
        .brc_o        (brc_o),
        .stall_o      (stall)
    );

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= 1'b0;
            rden_q  <= 1'b0;
            wren_q  <= 1'b0;
        end else if (!stall) begin
            valid_q <= req_valid_i;
            // no strobes from a bubble
            rden_q  <= req_valid_i && stage_res.rden;
            wren_q  <= req_valid_i && stage_res.wren;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            alures_q <= stage_res.alures;
            rs2_q    <= stage_res.rs2;
        end
    end

    assign res_o.alures = alures_q;
    assign res_o.rs2    = rs2_q;
    assign res_o.rden   = rden_q;
    assign res_o.wren   = wren_q;
    assign res_o.valid  = valid_q;

    assign stall_o = stall;

endmodule
